// File: src/chacha_pkg.sv
`default_nettype none

package chacha_pkg;

  // --------------------
  // Widths
  // --------------------
  typedef logic [31:0]  word_t;          // One state word
  typedef logic [255:0] key_t;           // Key word 0 in bits [255:224]
  typedef logic [95:0]  nonce_t;         // Nonce word 0 in bits [95:64]
  typedef logic [511:0] block_t;         // Data in/out, word 0 on top
  typedef word_t [15:0] state_t;         // Word i sits at index i
  typedef logic [4:0]   rounds_t;        // Round count, bit 0 unused
  typedef logic [3:0]   dr_cnt_t;        // Double-round index

  // --------------------
  // Bundles
  // --------------------
  typedef struct packed {
    word_t a;                            // Top 32 bits
    word_t b;
    word_t c;
    word_t d;
  } qr_operand_t;

  typedef struct packed {
    key_t   key;                         // Latched on init
    nonce_t nonce;
    word_t  ctr;                         // Starting block counter
  } chacha_cfg_t;

  // expand 32-byte k
  localparam word_t SIGMA0 = 32'h61707865;
  localparam word_t SIGMA1 = 32'h3320646e;
  localparam word_t SIGMA2 = 32'h79622d32;
  localparam word_t SIGMA3 = 32'h6b206574;

  typedef enum logic [2:0] {
    CTRL_IDLE,                           // Waiting for init
    CTRL_INIT,                           // Load working state
    CTRL_ROUNDS,                         // One step per clock
    CTRL_FINALIZE,                       // Capture output block
    CTRL_DONE                            // Output held, init or next
  } ctrl_state_e;

  // Little-endian word view of a big-endian slice
  function automatic word_t byte_swap(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

`default_nettype wire

// File: src/chacha_qr.sv
`timescale 1ns/1ns
`default_nettype none

module chacha_qr (
  input  wire chacha_pkg::qr_operand_t in,
  output chacha_pkg::qr_operand_t      out
);

  import chacha_pkg::*;

  word_t a;                                  // Working copies
  word_t b;
  word_t c;
  word_t d;

  always_comb
  begin
    a = in.a;
    b = in.b;
    c = in.c;
    d = in.d;

    a = a + b;                               // Stage 1
    d = d ^ a;
    d = {d[15:0], d[31:16]};                 // Rotate left 16

    c = c + d;                               // Stage 2
    b = b ^ c;
    b = {b[19:0], b[31:20]};                 // Rotate left 12

    a = a + b;                               // Stage 3
    d = d ^ a;
    d = {d[23:0], d[31:24]};                 // Rotate left 8

    c = c + d;                               // Stage 4
    b = b ^ c;
    b = {b[24:0], b[31:25]};                 // Rotate left 7

    out.a = a;
    out.b = b;
    out.c = c;
    out.d = d;
  end

endmodule

`default_nettype wire

// File: src/chacha_block_setup.sv
`timescale 1ns/1ns
`default_nettype none

module chacha_block_setup (
  input  wire                          clk,
  input  wire                          dr_ctr_rst,
  input  wire chacha_pkg::chacha_cfg_t cfg,
  input  wire                          ctr_set,
  input  wire                          ctr_inc,
  output chacha_pkg::state_t           init_state
);

  import chacha_pkg::*;

  key_t   key_q;                             // Key as loaded by init
  nonce_t nonce_q;                           // Nonce as loaded by init
  word_t  block_ctr;                         // State word 12

  // --------------------
  // Loaded parameters
  // --------------------
  always_ff @(posedge clk)
  begin
    if (ctr_set)
    begin
      key_q   <= cfg.key;                    // Kept across next commands
      nonce_q <= cfg.nonce;
    end
  end

  always_ff @(posedge clk)
  begin
    if (dr_ctr_rst)
      block_ctr <= '0;
    else if (ctr_set)
      block_ctr <= cfg.ctr;                  // Fresh start on init
    else if (ctr_inc)
      block_ctr <= block_ctr + 32'd1;        // Wraps modulo 2^32 on next
  end

  // --------------------
  // Initial matrix
  // --------------------
  always_comb
  begin
    init_state[0] = SIGMA0;                  // Row 0 is the constant
    init_state[1] = SIGMA1;
    init_state[2] = SIGMA2;
    init_state[3] = SIGMA3;
    for (int i = 0; i < 8; i++)
      init_state[4 + i] = byte_swap(key_q[255 - 32 * i -: 32]);   // Rows 1 and 2
    init_state[12] = block_ctr;              // Counter goes in as is
    for (int j = 0; j < 3; j++)
      init_state[13 + j] = byte_swap(nonce_q[95 - 32 * j -: 32]); // Words 13..15
  end

  // Controller issues at most one counter update per accepted command
  a_ctr_one_hot : assert property (@(posedge clk) disable iff (dr_ctr_rst)
    !(ctr_set && ctr_inc))
    else $error("ctr_set and ctr_inc asserted together");

endmodule

`default_nettype wire

// File: src/chacha_round.sv
`timescale 1ns/1ns
`default_nettype none

module chacha_round (
  input  wire                     clk,
  input  wire                     dr_ctr_rst,
  input  wire                     load,
  input  wire                     step,
  input  wire chacha_pkg::state_t init_state,
  output chacha_pkg::state_t      work_state,
  output logic                    diag_done
);

  import chacha_pkg::*;

  logic        diag_step;                    // 0 column step, 1 diagonal step
  state_t      next_state;                   // Result of this step
  qr_operand_t qr_in  [4];                   // One operand per lane
  qr_operand_t qr_out [4];

  // Word index for a row and lane, diagonals shift row r by r lanes
  function automatic int lane_idx(input int row, input int lane, input logic diag);
    int col;
    col = diag ? ((lane + row) % 4) : lane;
    return row * 4 + col;
  endfunction

  // --------------------
  // Operand routing
  // --------------------
  always_comb
  begin
    for (int g = 0; g < 4; g++)
    begin
      qr_in[g].a = work_state[lane_idx(0, g, diag_step)];
      qr_in[g].b = work_state[lane_idx(1, g, diag_step)];
      qr_in[g].c = work_state[lane_idx(2, g, diag_step)];
      qr_in[g].d = work_state[lane_idx(3, g, diag_step)];
    end
  end

  for (genvar g = 0; g < 4; g++)
  begin : g_qr
    chacha_qr u_qr (
      .in  (qr_in[g]),
      .out (qr_out[g])
    );
  end

  // Write back along the same pattern, all sixteen words
  always_comb
  begin
    next_state = work_state;                 // Every word is overwritten below
    for (int g = 0; g < 4; g++)
    begin
      next_state[lane_idx(0, g, diag_step)] = qr_out[g].a;
      next_state[lane_idx(1, g, diag_step)] = qr_out[g].b;
      next_state[lane_idx(2, g, diag_step)] = qr_out[g].c;
      next_state[lane_idx(3, g, diag_step)] = qr_out[g].d;
    end
  end

  // --------------------
  // Working state
  // --------------------
  always_ff @(posedge clk)
  begin
    if (load)
      work_state <= init_state;              // Start of a block
    else if (step)
      work_state <= next_state;
  end

  always_ff @(posedge clk)
  begin
    if (dr_ctr_rst)
      diag_step <= 1'b0;
    else if (load)
      diag_step <= 1'b0;                     // First step is a column step
    else if (step)
      diag_step <= ~diag_step;               // Alternate every clock
  end

  assign diag_done = step && diag_step;      // Closes one double round

  // Load comes only from INIT and step only from ROUNDS
  a_load_step_excl : assert property (@(posedge clk) disable iff (dr_ctr_rst)
    !(load && step))
    else $error("load and step asserted together");

endmodule

`default_nettype wire

// File: src/chacha_finalize.sv
`timescale 1ns/1ns
`default_nettype none

module chacha_finalize (
  input  wire                     clk,
  input  wire                     dr_ctr_rst,
  input  wire                     capture,
  input  wire chacha_pkg::state_t init_state,
  input  wire chacha_pkg::state_t work_state,
  input  wire chacha_pkg::block_t data_in,
  output chacha_pkg::block_t      data_out
);

  import chacha_pkg::*;

  state_t sum_state;                         // Feed-forward sums
  block_t keystream;                         // Word 0 in the top bits

  // --------------------
  // Keystream
  // --------------------
  always_comb
  begin
    for (int i = 0; i < 16; i++)
    begin
      sum_state[i] = init_state[i] + work_state[i];              // Modulo 2^32
      keystream[511 - 32 * i -: 32] = byte_swap(sum_state[i]);   // Little-endian bytes
    end
  end

  // --------------------
  // Output register
  // --------------------
  always_ff @(posedge clk)
  begin
    if (dr_ctr_rst)
      data_out <= '0;
    else if (capture)
      data_out <= data_in ^ keystream;       // Held until the next capture
  end

endmodule

`default_nettype wire

// File: src/chacha_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module chacha_ctrl (
  input  wire                      clk,
  input  wire                      dr_ctr_rst,
  input  wire                      init,
  input  wire                      next,
  input  wire chacha_pkg::rounds_t rounds,
  input  wire                      diag_done,
  output logic                     ctr_set,
  output logic                     ctr_inc,
  output logic                     load,
  output logic                     step,
  output logic                     capture,
  output logic                     ready,
  output logic                     data_out_valid
);

  import chacha_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  dr_cnt_t     dr_cnt;                       // Double rounds done so far
  logic        accept_init;
  logic        accept_next;
  logic        last_dr;                      // Final double round in progress

  // --------------------
  // Command decode
  // --------------------
  assign accept_init = init && (state_q == CTRL_IDLE || state_q == CTRL_DONE);
  assign accept_next = next && !init && (state_q == CTRL_DONE);   // init wins

  assign ctr_set = accept_init;
  assign ctr_inc = accept_next;
  assign load    = (state_q == CTRL_INIT);
  assign step    = (state_q == CTRL_ROUNDS);
  assign capture = (state_q == CTRL_FINALIZE);

  assign last_dr = (dr_cnt == rounds[4:1] - 4'd1);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE, CTRL_DONE:
        if (accept_init || accept_next)
          state_d = CTRL_INIT;
      CTRL_INIT:
        state_d = CTRL_ROUNDS;
      CTRL_ROUNDS:
        if (diag_done && last_dr)
          state_d = CTRL_FINALIZE;           // R steps taken
      CTRL_FINALIZE:
        state_d = CTRL_DONE;
      default:
        state_d = CTRL_IDLE;
    endcase
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk)
  begin
    if (dr_ctr_rst)
      state_q <= CTRL_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk)
  begin
    if (dr_ctr_rst)
      dr_cnt <= '0;
    else if (load)
      dr_cnt <= '0;
    else if (diag_done)
      dr_cnt <= dr_cnt + 4'd1;
  end

  always_ff @(posedge clk)
  begin
    if (dr_ctr_rst)
    begin
      ready          <= 1'b1;
      data_out_valid <= 1'b0;
    end
    else if (accept_init || accept_next)
    begin
      ready          <= 1'b0;                // Busy from the command edge
      data_out_valid <= 1'b0;
    end
    else if (capture)
    begin
      ready          <= 1'b1;                // Same edge as data_out
      data_out_valid <= 1'b1;
    end
  end

  // Output levels track the state register
  a_valid_ready : assert property (@(posedge clk) disable iff (dr_ctr_rst)
    data_out_valid |-> (ready && state_q == CTRL_DONE))
    else $error("data_out_valid without ready in DONE");

  // Zero double rounds would wrap to sixteen
  a_rounds_nonzero : assert property (@(posedge clk) disable iff (dr_ctr_rst)
    (accept_init || accept_next) |-> (rounds[4:1] != 4'd0))
    else $error("command accepted with rounds below 2");

endmodule

`default_nettype wire

// File: src/chacha_core.sv
`timescale 1ns/1ns
`default_nettype none

module chacha_core (
  input  wire                          clk,
  input  wire                          dr_ctr_rst,
  input  wire                          init,
  input  wire                          next,
  input  wire chacha_pkg::chacha_cfg_t cfg,
  input  wire chacha_pkg::rounds_t     rounds,
  input  wire chacha_pkg::block_t      data_in,
  output wire                          ready,
  output wire chacha_pkg::block_t      data_out,
  output wire                          data_out_valid
);

  import chacha_pkg::*;

  // --------------------
  // Strobes and states
  // --------------------
  wire    ctr_set;
  wire    ctr_inc;
  wire    load;
  wire    step;
  wire    capture;
  wire    diag_done;                         // One per double round
  state_t init_state;                        // Constants, key, counter, nonce
  state_t work_state;                        // After the steps so far

  chacha_ctrl u_ctrl (
    .clk            (clk),
    .dr_ctr_rst     (dr_ctr_rst),
    .init           (init),
    .next           (next),
    .rounds         (rounds),
    .diag_done      (diag_done),
    .ctr_set        (ctr_set),
    .ctr_inc        (ctr_inc),
    .load           (load),
    .step           (step),
    .capture        (capture),
    .ready          (ready),
    .data_out_valid (data_out_valid)
  );

  chacha_block_setup u_block_setup (
    .clk        (clk),
    .dr_ctr_rst (dr_ctr_rst),
    .cfg        (cfg),
    .ctr_set    (ctr_set),
    .ctr_inc    (ctr_inc),
    .init_state (init_state)
  );

  chacha_round u_round (
    .clk        (clk),
    .dr_ctr_rst (dr_ctr_rst),
    .load       (load),
    .step       (step),
    .init_state (init_state),
    .work_state (work_state),
    .diag_done  (diag_done)
  );

  chacha_finalize u_finalize (
    .clk        (clk),
    .dr_ctr_rst (dr_ctr_rst),
    .capture    (capture),
    .init_state (init_state),
    .work_state (work_state),
    .data_in    (data_in),
    .data_out   (data_out)
  );

endmodule

`default_nettype wire

// File: tb/chacha_checker.sv
`timescale 1ns/1ns
`default_nettype none

module chacha_checker (
  input wire                          clk,
  input wire                          dr_ctr_rst,
  input wire                          init,
  input wire                          next,
  input wire chacha_pkg::chacha_cfg_t cfg,
  input wire chacha_pkg::rounds_t     rounds,
  input wire chacha_pkg::block_t      data_in,
  input wire                          ready,
  input wire chacha_pkg::block_t      data_out,
  input wire                          data_out_valid
);

  import chacha_pkg::*;

  typedef enum int {M_UNKNOWN, M_IDLE, M_BUSY, M_DONE} model_e;

  model_e  mstate = M_UNKNOWN;               // Expected controller phase
  int      err_count = 0;
  int      block_count = 0;                  // Blocks compared so far
  int      cyc;                              // Edges since the command edge
  int      lat;                              // Expected edges to data_out_valid
  key_t    m_key;
  nonce_t  m_nonce;
  word_t   m_ctr;                            // Tracks next commands
  rounds_t m_rounds;
  block_t  held;                             // Value data_out must keep
  block_t  din_seen;                         // data_in at the last edge
  block_t  expect_out;

  // --------------------
  // Reference model
  // --------------------
  function automatic word_t rotl(input word_t w, input int n);
    return (w << n) | (w >> (32 - n));
  endfunction

  function automatic word_t le_word(input word_t w);
    word_t r;
    for (int k = 0; k < 4; k++)
      r[8 * k +: 8] = w[31 - 8 * k -: 8];    // First byte becomes the low byte
    return r;
  endfunction

  function automatic logic [127:0] quarter(input logic [127:0] v);
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    {a, b, c, d} = v;
    a = a + b;
    d = rotl(d ^ a, 16);
    c = c + d;
    b = rotl(b ^ c, 12);
    a = a + b;
    d = rotl(d ^ a, 8);
    c = c + d;
    b = rotl(b ^ c, 7);
    return {a, b, c, d};
  endfunction

  function automatic block_t keystream(input key_t k, input nonce_t n, input word_t ctr,
                                       input rounds_t r);
    word_t  x  [16];
    word_t  x0 [16];
    block_t ks;
    x[0] = 32'h61707865;                     // "expa"
    x[1] = 32'h3320646e;
    x[2] = 32'h79622d32;
    x[3] = 32'h6b206574;
    for (int i = 0; i < 8; i++)
      x[4 + i] = le_word(k[255 - 32 * i -: 32]);
    x[12] = ctr;
    for (int j = 0; j < 3; j++)
      x[13 + j] = le_word(n[95 - 32 * j -: 32]);
    x0 = x;
    for (int dr = 0; dr < int'(r[4:1]); dr++)
    begin
      {x[0], x[4], x[8],  x[12]} = quarter({x[0], x[4], x[8],  x[12]});   // Columns
      {x[1], x[5], x[9],  x[13]} = quarter({x[1], x[5], x[9],  x[13]});
      {x[2], x[6], x[10], x[14]} = quarter({x[2], x[6], x[10], x[14]});
      {x[3], x[7], x[11], x[15]} = quarter({x[3], x[7], x[11], x[15]});
      {x[0], x[5], x[10], x[15]} = quarter({x[0], x[5], x[10], x[15]});   // Diagonals
      {x[1], x[6], x[11], x[12]} = quarter({x[1], x[6], x[11], x[12]});
      {x[2], x[7], x[8],  x[13]} = quarter({x[2], x[7], x[8],  x[13]});
      {x[3], x[4], x[9],  x[14]} = quarter({x[3], x[4], x[9],  x[14]});
    end
    for (int i = 0; i < 16; i++)
      ks[511 - 32 * i -: 32] = le_word(x[i] + x0[i]);   // Feed-forward
    return ks;
  endfunction

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic start_block();
    m_rounds = rounds;
    lat      = 2 * int'(rounds[4:1]) + 2;    // Steps plus load and capture
    cyc      = 0;
    mstate   = M_BUSY;
  endtask

  // --------------------
  // Watcher
  // --------------------
  // Outputs of the last edge are checked first, then the inputs for the coming edge
  always @(negedge clk)
  begin
    case (mstate)
      M_IDLE, M_DONE:
      begin
        if (ready !== 1'b1 || data_out_valid !== (mstate == M_DONE))
          report_error("ready or data_out_valid wrong with no command running");
        if (data_out !== held)
          report_error("data_out changed with no command running");
      end
      M_BUSY:
      begin
        if (cyc < lat)
        begin
          if (ready !== 1'b0 || data_out_valid !== 1'b0)
            report_error($sformatf("ready or data_out_valid high %0d cycles in", cyc));
        end
        else
        begin
          expect_out = din_seen ^ keystream(m_key, m_nonce, m_ctr, m_rounds);
          if (ready !== 1'b1 || data_out_valid !== 1'b1)
            report_error($sformatf("ready or data_out_valid low %0d cycles in", cyc));
          if (data_out !== expect_out)
            report_error($sformatf("data_out mismatch for counter %08h", m_ctr));
          if (m_key == '0 && m_nonce == '0 && m_ctr == '0 && m_rounds == 5'd20
              && din_seen == '0 && data_out[511:480] !== 32'h76b8e0ad)
            report_error("known answer word 0 is not 76b8e0ad");
          held   = expect_out;
          mstate = M_DONE;
          block_count++;
        end
        cyc++;
      end
      default: ;
    endcase

    if (dr_ctr_rst)
    begin
      mstate = M_IDLE;
      held   = '0;                           // Reset value of data_out
    end
    else if (init && (mstate == M_IDLE || mstate == M_DONE))
    begin
      m_key   = cfg.key;
      m_nonce = cfg.nonce;
      m_ctr   = cfg.ctr;
      start_block();
    end
    else if (next && mstate == M_DONE)
    begin
      m_ctr = m_ctr + 32'd1;                 // Same key, following block
      start_block();
    end
    din_seen = data_in;
  end

endmodule

`default_nettype wire

// File: tb/tb_chacha.sv
`timescale 1ns/1ns
`default_nettype none

module tb_chacha;

  import chacha_pkg::*;

  localparam logic [31:0] LFSR_TAPS  = 32'h80200003;
  localparam logic [31:0] LFSR_SEED  = 32'd78;
  localparam int          WAIT_LIMIT = 100;  // Cycles, well above 20 rounds

  logic        clk;
  logic        dr_ctr_rst;
  logic        init;
  logic        next;
  chacha_cfg_t cfg;
  rounds_t     rounds;
  block_t      data_in;
  wire         ready;
  wire block_t data_out;
  wire         data_out_valid;
  logic [31:0] lfsr;
  int          timeout_count;
  int          expected_blocks;              // Commands the core should accept

  always #2 clk = ~clk;                      // 4 ns period

  chacha_core u_dut (
    .clk            (clk),
    .dr_ctr_rst     (dr_ctr_rst),
    .init           (init),
    .next           (next),
    .cfg            (cfg),
    .rounds         (rounds),
    .data_in        (data_in),
    .ready          (ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid)
  );

  chacha_checker u_chk (
    .clk            (clk),
    .dr_ctr_rst     (dr_ctr_rst),
    .init           (init),
    .next           (next),
    .cfg            (cfg),
    .rounds         (rounds),
    .data_in        (data_in),
    .ready          (ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid)
  );

  // --------------------
  // Random bits
  // --------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);   // Galois, shift right
  endfunction

  task automatic random_bits(input int n, output logic [511:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[510:0], lfsr[0]};            // One step per bit
    end
  endtask

  task automatic draw_cfg();
    logic [511:0] v;
    random_bits(256, v);
    cfg.key = v[255:0];
    random_bits(96, v);
    cfg.nonce = v[95:0];
    random_bits(32, v);
    cfg.ctr = v[31:0];
  endtask

  task automatic draw_data();
    logic [511:0] v;
    random_bits(512, v);
    data_in = v;
  endtask

  task automatic draw_rounds();
    logic [511:0] v;
    random_bits(2, v);
    case (v[1:0])
      2'd0:    rounds = 5'd8;
      2'd1:    rounds = 5'd12;
      default: rounds = 5'd20;
    endcase
  endtask

  // --------------------
  // Commands and waits
  // --------------------
  task automatic send_cmd(input logic do_init, input logic do_next);
    @(posedge clk);
    #1;
    init = do_init;
    next = do_next;
    @(posedge clk);                          // Command edge
    #1;
    init = 1'b0;
    next = 1'b0;
  endtask

  task automatic hold_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_done();
    int cnt;
    cnt = 0;
    while (!(ready && data_out_valid) && cnt < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!(ready && data_out_valid))
    begin
      $display("Timeout at %0t ns: data_out_valid did not rise within %0d cycles",
               $time, WAIT_LIMIT);
      timeout_count++;
    end
  endtask

  task automatic run_block(input logic do_init, input logic do_next);
    send_cmd(do_init, do_next);
    expected_blocks++;
    wait_done();
  endtask

  task automatic report_and_finish();
    int count_errors;
    count_errors = (u_chk.block_count != expected_blocks) ? 1 : 0;
    if (count_errors != 0)
      $display("Wrong number of blocks checked: %0d expected, %0d seen",
               expected_blocks, u_chk.block_count);
    $display("Totals: mismatches %0d, timeouts %0d, block count errors %0d",
             u_chk.err_count, timeout_count, count_errors);
    if (u_chk.err_count == 0 && timeout_count == 0 && count_errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial
  begin
    clk             = 1'b0;
    dr_ctr_rst      = 1'b1;
    init            = 1'b0;
    next            = 1'b0;
    cfg             = '0;
    rounds          = 5'd20;
    data_in         = '0;
    lfsr            = LFSR_SEED;
    timeout_count   = 0;
    expected_blocks = 0;
    repeat (3) @(posedge clk);
    #1;
    dr_ctr_rst = 1'b0;

    send_cmd(1'b0, 1'b1);                    // next in IDLE, ignored
    hold_cycles(4);

    run_block(1'b1, 1'b0);                   // All-zero known answer
    hold_cycles(3);

    for (int n = 0; n < 8; n++)
    begin
      draw_cfg();
      draw_data();
      draw_rounds();
      run_block(1'b1, 1'b0);
      hold_cycles(2);                        // data_out must hold in DONE
    end

    for (int c = 0; c < 2; c++)
    begin
      draw_cfg();
      if (c == 1)
        cfg.ctr = '1;                        // Wraps to 0 on the first next
      draw_data();
      draw_rounds();
      run_block(1'b1, 1'b0);
      for (int k = 0; k < 3; k++)
      begin
        draw_data();                         // New plaintext per block
        run_block(1'b0, 1'b1);
      end
    end

    draw_cfg();
    draw_data();
    rounds = 5'd20;
    send_cmd(1'b1, 1'b0);
    expected_blocks++;
    hold_cycles(2);
    draw_cfg();                              // Busy, must not be taken
    send_cmd(1'b1, 1'b0);
    send_cmd(1'b0, 1'b1);
    send_cmd(1'b1, 1'b1);
    wait_done();
    hold_cycles(3);

    report_and_finish();
  end

endmodule

`default_nettype wire

// File: flist.f
src/chacha_pkg.sv
src/chacha_qr.sv
src/chacha_block_setup.sv
src/chacha_round.sv
src/chacha_finalize.sv
src/chacha_ctrl.sv
src/chacha_core.sv
tb/chacha_checker.sv
tb/tb_chacha.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_chacha
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
	  echo "TEST FAILED"; exit 1; \
	else \
	  echo "TEST PASSED"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
